// ==== sources.f ====
+incdir+bench
source/procPkg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/proc.sv
bench/proc_properties.sv
bench/procTb.sv

// ==== Bender.yml ====
package:
  name: proc

sources:
  - files:
      - source/procPkg.sv
      - source/fetch.sv
      - source/decode.sv
      - source/execute.sv
      - source/memory.sv
      - source/proc.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/proc_properties.sv
      - bench/procTb.sv

// ==== bench/procTable.svh ====
/* Test programs for the processor testbench and the writeback stream each one produces
   Expected beats are {register, value} in program order, missing words load as HALT */
`ifndef PROC_TABLE_SVH
`define PROC_TABLE_SVH

localparam int NumTests = 6;

logic [procPkg::DataWidth-1:0] progTable [NumTests][$];
logic [BeatWidth-1:0]          wbTable   [NumTests][$];
logic                          errTable  [NumTests];

function automatic void fillTable();
    // R-type ops on ADDI-built 12 and 10
    progTable[0] = '{iOp(procPkg::opAddi, 1, 0, 12), iOp(procPkg::opAddi, 2, 0, 10),
                     rOp(procPkg::fnAdd, 3, 1, 2), rOp(procPkg::fnSub, 4, 1, 2),
                     rOp(procPkg::fnAnd, 5, 1, 2), rOp(procPkg::fnXor, 6, 1, 2)};
    wbTable[0]   = '{beat(1, 12), beat(2, 10), beat(3, 22), beat(4, 2), beat(5, 8), beat(6, 6)};
    errTable[0]  = 1'b0;
    // Negative imm5 sign-extends to 16 bits
    progTable[1] = '{iOp(procPkg::opAddi, 1, 0, -3), iOp(procPkg::opXori, 2, 1, -1),
                     iOp(procPkg::opAddi, 3, 0, 15), iOp(procPkg::opXori, 4, 3, -16),
                     rOp(procPkg::fnSub, 5, 0, 3)};
    wbTable[1]   = '{beat(1, 'hFFFD), beat(2, 'h0002), beat(3, 'h000F), beat(4, 'hFFFF),
                     beat(5, 'hFFF1)};
    errTable[1]  = 1'b0;
    // Dependent chain, no NOPs
    progTable[2] = '{iOp(procPkg::opAddi, 1, 0, 1), iOp(procPkg::opAddi, 1, 1, 2),
                     rOp(procPkg::fnAdd, 2, 1, 1), rOp(procPkg::fnSub, 2, 2, 1),
                     iOp(procPkg::opXori, 3, 2, 5), rOp(procPkg::fnAdd, 7, 3, 2)};
    wbTable[2]   = '{beat(1, 1), beat(1, 3), beat(2, 6), beat(2, 3), beat(3, 6), beat(7, 9)};
    errTable[2]  = 1'b0;
    // ST then LD at 8, then at 3 via negative offset
    progTable[3] = '{iOp(procPkg::opAddi, 1, 0, 7), iOp(procPkg::opAddi, 2, 0, 5),
                     iOp(procPkg::opSt, 1, 2, 3), iOp(procPkg::opLd, 3, 2, 3),
                     iOp(procPkg::opAddi, 4, 0, -9), iOp(procPkg::opSt, 4, 2, -2),
                     iOp(procPkg::opLd, 5, 2, -2)};
    wbTable[3]   = '{beat(1, 7), beat(2, 5), beat(3, 7), beat(4, 'hFFF7), beat(5, 'hFFF7)};
    errTable[3]  = 1'b0;
    // Taken at 1 skips 2 and 3, untaken at 4, taken at 8 skips 9
    progTable[4] = '{iOp(procPkg::opAddi, 1, 0, 4), iOp(procPkg::opBeqz, 0, 0, 2),
                     iOp(procPkg::opAddi, 2, 0, 9), iOp(procPkg::opAddi, 3, 0, 9),
                     iOp(procPkg::opBeqz, 0, 1, 1), iOp(procPkg::opAddi, 4, 0, 5),
                     iOp(procPkg::opAddi, 5, 1, -1), rOp(procPkg::fnSub, 6, 1, 1),
                     iOp(procPkg::opBeqz, 0, 6, 1), iOp(procPkg::opAddi, 7, 0, 1)};
    wbTable[4]   = '{beat(1, 4), beat(4, 5), beat(5, 3), beat(6, 0)};
    errTable[4]  = 1'b0;
    // Opcode 11111 is illegal, word after HALT never runs
    progTable[5] = '{iOp(procPkg::opAddi, 1, 0, 3), 16'hFFFF, iOp(procPkg::opAddi, 2, 1, 4),
                     HaltWord, iOp(procPkg::opAddi, 3, 0, 1)};
    wbTable[5]   = '{beat(1, 3), beat(2, 7)};
    errTable[5]  = 1'b1;
endfunction

`endif

// ==== bench/procTb.sv ====
/* Testbench for the five-stage processor
   Loads each table program, runs it to HALT and checks the writeback stream and flags */
module procTb;

    localparam int ClkPeriod     = 10;
    localparam int ImemWords     = 64;  // DUT default
    localparam int LoadWords     = 32;  // Program slots plus HALT padding
    localparam int TailCycles    = 8;   // Watch for stray writebacks after halt
    localparam int CyclesPerTest = 200;
    localparam int BeatWidth     = procPkg::RegAddrWidth + procPkg::DataWidth;
    localparam logic [procPkg::DataWidth-1:0] HaltWord = {procPkg::opHalt, 11'b0};

    logic                             clk = 1'b0;
    logic                             reset;
    logic                             run;
    logic                             imemWrite;
    logic [$clog2(ImemWords)-1:0]     imemAddr;
    logic [procPkg::DataWidth-1:0]    imemData;
    logic                             wbValid;
    logic [procPkg::RegAddrWidth-1:0] wbAddr;
    logic [procPkg::DataWidth-1:0]    wbData;
    logic                             halted;
    logic                             err;

    int writeErrors  = 0;
    int flagErrors   = 0;
    int streamErrors = 0; // Missing or extra beats
    int curTest      = 0;

    // Assemble opcode | rs | rt | rd | funct
    function automatic logic [procPkg::DataWidth-1:0] rOp(input procPkg::functT fn,
                                                          input int rd, input int rs, input int rt);
        return {procPkg::opRType, rs[2:0], rt[2:0], rd[2:0], fn};
    endfunction

    // Assemble opcode | rs | rd | imm5
    function automatic logic [procPkg::DataWidth-1:0] iOp(input procPkg::opcodeT op,
                                                          input int rd, input int rs, input int imm);
        return {op, rs[2:0], rd[2:0], imm[4:0]};
    endfunction

    function automatic logic [BeatWidth-1:0] beat(input int r, input int v);
        return {r[procPkg::RegAddrWidth-1:0], v[procPkg::DataWidth-1:0]};
    endfunction

    `include "procTable.svh"

    always #(ClkPeriod / 2) clk = ~clk;

    proc DUT (
        .clk, .reset, .run, .imemWrite, .imemAddr, .imemData,
        .wbValid, .wbAddr, .wbData, .halted, .err
    );

    task automatic checkWrite(input int idx,
                              input logic [procPkg::RegAddrWidth-1:0] expAddr,
                              input logic [procPkg::DataWidth-1:0]    expData,
                              input logic [procPkg::RegAddrWidth-1:0] gotAddr,
                              input logic [procPkg::DataWidth-1:0]    gotData);
        if (gotAddr !== expAddr || gotData !== expData) begin
            writeErrors++;
            $display("FAILED at time %0t: test %0d beat %0d expected r%0d = %h, got r%0d = %h",
                     $time, curTest, idx, expAddr, expData, gotAddr, gotData);
        end
    endtask

    task automatic checkFlag(input string name, input logic expBit, input logic gotBit);
        if (gotBit !== expBit) begin
            flagErrors++;
            $display("FAILED at time %0t: test %0d %s expected %b, got %b",
                     $time, curTest, name, expBit, gotBit);
        end
    endtask

    task automatic reportCounts();
        $display("Errors: %0d writeback, %0d flag, %0d stream",
                 writeErrors, flagErrors, streamErrors);
    endtask

    task automatic applyReset();
        @(posedge clk);
        reset     <= 1'b1;
        run       <= 1'b0;
        imemWrite <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Program words then HALT up to LoadWords
    task automatic loadProgram(input int t);
        for (int i = 0; i < LoadWords; i++) begin
            @(posedge clk);
            imemWrite <= 1'b1;
            imemAddr  <= i[$clog2(ImemWords)-1:0];
            imemData  <= (i < progTable[t].size()) ? progTable[t][i] : HaltWord;
        end
        @(posedge clk);
        imemWrite <= 1'b0;
    endtask

    task automatic runProgram(input int t);
        int                   got;
        logic [BeatWidth-1:0] exp;
        got = 0;
        @(posedge clk);
        run <= 1'b1;
        while (halted !== 1'b1) begin
            @(negedge clk); // Outputs settled mid-cycle
            if (wbValid === 1'b1) begin
                if (got < wbTable[t].size()) begin
                    exp = wbTable[t][got];
                    checkWrite(got, exp[procPkg::DataWidth +: procPkg::RegAddrWidth],
                               exp[procPkg::DataWidth-1:0], wbAddr, wbData);
                end else begin
                    streamErrors++;
                    $display("Test %0d has an extra writeback to r%0d at time %0t",
                             t, wbAddr, $time);
                end
                got++;
            end
        end
        repeat (TailCycles) begin
            @(negedge clk);
            if (wbValid !== 1'b0) begin
                streamErrors++;
                $display("Test %0d wrote back after halting, at time %0t", t, $time);
            end
        end
        if (got < wbTable[t].size()) begin
            streamErrors++;
            $display("Test %0d is missing writebacks, saw %0d of %0d",
                     t, got, wbTable[t].size());
        end
        checkFlag("err", errTable[t], err);
        checkFlag("halted", 1'b1, halted);
    endtask

    initial begin
        reset     <= 1'b1;
        run       <= 1'b0;
        imemWrite <= 1'b0;
        imemAddr  <= '0;
        imemData  <= '0;
        fillTable();
        for (int t = 0; t < NumTests; t++) begin
            curTest = t;
            applyReset();
            loadProgram(t);
            runProgram(t);
        end
        reportCounts();
        if (writeErrors + flagErrors + streamErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #(NumTests * CyclesPerTest * ClkPeriod);
        $display("Timed out: test %0d did not reach halted within %0d cycles in total",
                 curTest, NumTests * CyclesPerTest);
        reportCounts();
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== bench/proc_properties.sv ====
/* Concurrent checks on the processor top level
   Reset quiets writeback, halted and err are sticky, nothing retires after halt */
module procProperties (
    input logic clk,
    input logic reset,
    input logic wbValid,
    input logic halted,
    input logic err
);

    // Registered, so quiet the cycle after a reset edge
    wbQuietInReset: assert property (@(posedge clk) reset |=> !wbValid)
        else $error("wbValid high while reset is asserted");

    haltedSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted dropped without reset");

    noWbAfterHalt: assert property (@(posedge clk) disable iff (reset) halted |-> !wbValid)
        else $error("wbValid high after halted");

    errSticky: assert property (@(posedge clk) disable iff (reset) err |=> err)
        else $error("err dropped without reset");

endmodule

bind proc procProperties props (.clk, .reset, .wbValid, .halted, .err);

// ==== source/proc.sv ====
/* Five-stage 16-bit pipelined processor, top level
   Wires fetch, decode, execute and memory together */
module proc #(
    parameter int ImemWords = 64,
    parameter int DmemWords = 64
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               run,
    input  logic                               imemWrite,
    input  logic [$clog2(ImemWords)-1:0]       imemAddr,
    input  logic [procPkg::DataWidth-1:0]      imemData,
    output logic                               wbValid,
    output logic [procPkg::RegAddrWidth-1:0]   wbAddr,
    output logic [procPkg::DataWidth-1:0]      wbData,
    output logic                               halted,
    output logic                               err
);

    // IF/ID and decode feedback
    logic                             ifValid, stall, branchTaken, haltSeen;
    logic [procPkg::DataWidth-1:0]    ifInstr, ifPc, branchTarget;
    // ID/EX
    logic                             exValid, exUseImm, exRegWrite;
    logic                             exMemRead, exMemWrite, exHalt;
    procPkg::aluOpT                   exAluOp;
    logic [procPkg::DataWidth-1:0]    exOperandA, exOperandB, exImm, exStoreData;
    logic [procPkg::RegAddrWidth-1:0] exDest;
    // EX/MEM
    logic                             memValid, memRegWrite, memMemRead;
    logic                             memMemWrite, memHalt;
    logic [procPkg::DataWidth-1:0]    memAluOut, memStoreData;
    logic [procPkg::RegAddrWidth-1:0] memDest;

    fetch #(.ImemWords(ImemWords)) fetchStage (
        .clk, .reset, .run, .imemWrite, .imemAddr, .imemData,
        .stall, .branchTaken, .branchTarget, .haltSeen,
        .ifValid, .ifInstr, .ifPc
    );

    decode decodeStage (
        .clk, .reset, .ifValid, .ifInstr, .ifPc,
        .wbValid, .wbAddr, .wbData,                 // Register write port
        .memValid, .memDest, .memRegWrite,          // Hazard check on MEM
        .stall, .branchTaken, .branchTarget, .haltSeen, .err,
        .exValid, .exAluOp, .exUseImm, .exOperandA, .exOperandB, .exImm,
        .exStoreData, .exDest, .exRegWrite, .exMemRead, .exMemWrite, .exHalt
    );

    execute executeStage (
        .clk, .reset,
        .exValid, .exAluOp, .exUseImm, .exOperandA, .exOperandB, .exImm,
        .exStoreData, .exDest, .exRegWrite, .exMemRead, .exMemWrite, .exHalt,
        .memValid, .memAluOut, .memStoreData, .memDest, .memRegWrite,
        .memMemRead, .memMemWrite, .memHalt
    );

    memory #(.DmemWords(DmemWords)) memoryStage (
        .clk, .reset,
        .memValid, .memAluOut, .memStoreData, .memDest, .memRegWrite,
        .memMemRead, .memMemWrite, .memHalt,
        .wbValid, .wbAddr, .wbData, .halted
    );

endmodule

// ==== source/memory.sv ====
/* Memory stage: data memory, load or ALU select into MEM/WB, halted flag */
module memory #(
    parameter int DmemWords = 64
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               memValid,
    input  logic [procPkg::DataWidth-1:0]      memAluOut,
    input  logic [procPkg::DataWidth-1:0]      memStoreData,
    input  logic [procPkg::RegAddrWidth-1:0]   memDest,
    input  logic                               memRegWrite,
    input  logic                               memMemRead,
    input  logic                               memMemWrite,
    input  logic                               memHalt,
    output logic                               wbValid,
    output logic [procPkg::RegAddrWidth-1:0]   wbAddr,
    output logic [procPkg::DataWidth-1:0]      wbData,
    output logic                               halted
);

    logic [procPkg::DataWidth-1:0]  dmem [DmemWords];
    logic [$clog2(DmemWords)-1:0]   addr;
    logic                           wbHalt;

    assign addr = memAluOut[$clog2(DmemWords)-1:0]; // Wraps modulo DmemWords

    always_ff @(posedge clk) begin
        if (memValid && memMemWrite) begin
            dmem[addr] <= memStoreData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid <= 1'b0;
            wbHalt  <= 1'b0;
            halted  <= 1'b0;
        end else begin
            wbValid <= memValid && memRegWrite; // Writers only
            wbHalt  <= memValid && memHalt;
            halted  <= halted || wbHalt;        // One cycle after HALT in MEM/WB
        end
    end

    // MEM/WB payload, async read feeds it
    always_ff @(posedge clk) begin
        wbAddr <= memDest;
        wbData <= memMemRead ? dmem[addr] : memAluOut;
    end

endmodule

// ==== source/execute.sv ====
/* Execute stage: ALU on operand A and register or immediate B, then EX/MEM */
module execute (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               exValid,
    input  procPkg::aluOpT                     exAluOp,
    input  logic                               exUseImm,
    input  logic [procPkg::DataWidth-1:0]      exOperandA,
    input  logic [procPkg::DataWidth-1:0]      exOperandB,
    input  logic [procPkg::DataWidth-1:0]      exImm,
    input  logic [procPkg::DataWidth-1:0]      exStoreData,
    input  logic [procPkg::RegAddrWidth-1:0]   exDest,
    input  logic                               exRegWrite,
    input  logic                               exMemRead,
    input  logic                               exMemWrite,
    input  logic                               exHalt,
    output logic                               memValid,
    output logic [procPkg::DataWidth-1:0]      memAluOut,
    output logic [procPkg::DataWidth-1:0]      memStoreData,
    output logic [procPkg::RegAddrWidth-1:0]   memDest,
    output logic                               memRegWrite,
    output logic                               memMemRead,
    output logic                               memMemWrite,
    output logic                               memHalt
);

    logic [procPkg::DataWidth-1:0] operandB;
    logic [procPkg::DataWidth-1:0] aluOut;

    assign operandB = exUseImm ? exImm : exOperandB;

    always_comb begin
        case (exAluOp)
            procPkg::aluAdd: aluOut = exOperandA + operandB; // Also LD/ST address
            procPkg::aluSub: aluOut = exOperandA - operandB;
            procPkg::aluAnd: aluOut = exOperandA & operandB;
            default:         aluOut = exOperandA ^ operandB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) memValid <= 1'b0;
        else       memValid <= exValid;
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        memAluOut    <= aluOut;
        memStoreData <= exStoreData;
        memDest      <= exDest;
        memRegWrite  <= exRegWrite;
        memMemRead   <= exMemRead;
        memMemWrite  <= exMemWrite;
        memHalt      <= exHalt;
    end

endmodule

// ==== source/decode.sv ====
/* Decode stage: control decode, register file with write bypass, hazard stall,
   BEQZ resolution, sticky illegal-opcode flag and the ID/EX register */
module decode (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               ifValid,
    input  logic [procPkg::DataWidth-1:0]      ifInstr,
    input  logic [procPkg::DataWidth-1:0]      ifPc,
    input  logic                               wbValid,
    input  logic [procPkg::RegAddrWidth-1:0]   wbAddr,
    input  logic [procPkg::DataWidth-1:0]      wbData,
    input  logic                               memValid,
    input  logic [procPkg::RegAddrWidth-1:0]   memDest,
    input  logic                               memRegWrite,
    output logic                               stall,
    output logic                               branchTaken,
    output logic [procPkg::DataWidth-1:0]      branchTarget,
    output logic                               haltSeen,
    output logic                               err,
    output logic                               exValid,
    output procPkg::aluOpT                     exAluOp,
    output logic                               exUseImm,
    output logic [procPkg::DataWidth-1:0]      exOperandA,
    output logic [procPkg::DataWidth-1:0]      exOperandB,
    output logic [procPkg::DataWidth-1:0]      exImm,
    output logic [procPkg::DataWidth-1:0]      exStoreData,
    output logic [procPkg::RegAddrWidth-1:0]   exDest,
    output logic                               exRegWrite,
    output logic                               exMemRead,
    output logic                               exMemWrite,
    output logic                               exHalt
);

    procPkg::instrWord                instr;
    logic [procPkg::DataWidth-1:0]    regs [1 << procPkg::RegAddrWidth];
    logic [procPkg::RegAddrWidth-1:0] srcA;
    logic [procPkg::RegAddrWidth-1:0] srcB;
    logic [procPkg::RegAddrWidth-1:0] dest;
    logic [procPkg::DataWidth-1:0]    readA;
    logic [procPkg::DataWidth-1:0]    readB;
    logic [procPkg::DataWidth-1:0]    immExt;
    procPkg::aluOpT                   aluOp;
    logic useA, useB, useImm, regWrite;
    logic memRead, memWrite, isBranch, isHalt, illegal;
    logic hazA, hazB, haltReg;

    assign instr  = ifInstr;
    assign srcA   = instr.rType.rs;
    assign srcB   = instr.rType.rt; // Also iType.rd for ST data
    assign immExt = {{(procPkg::DataWidth-5){instr.iType.imm5[4]}}, instr.iType.imm5};

    // Opcode to controls
    always_comb begin
        {useA, useB, useImm, regWrite} = '0;
        {memRead, memWrite, isBranch, isHalt, illegal} = '0;
        aluOp = procPkg::aluAdd;
        dest  = instr.iType.rd; // I-type target by default
        case (instr.rType.opcode)
            procPkg::opRType: begin
                {useA, useB, regWrite} = 3'b111;
                dest = instr.rType.rd;
                case (instr.rType.funct)
                    procPkg::fnAdd: aluOp = procPkg::aluAdd;
                    procPkg::fnSub: aluOp = procPkg::aluSub;
                    procPkg::fnAnd: aluOp = procPkg::aluAnd;
                    default:        aluOp = procPkg::aluXor;
                endcase
            end
            procPkg::opAddi: {useA, useImm, regWrite} = 3'b111;
            procPkg::opXori: begin
                {useA, useImm, regWrite} = 3'b111;
                aluOp = procPkg::aluXor;
            end
            procPkg::opLd:   {useA, useImm, regWrite, memRead} = 4'b1111;
            procPkg::opSt:   {useA, useB, useImm, memWrite} = 4'b1111; // Address rs+imm
            procPkg::opBeqz: {useA, isBranch} = 2'b11;
            procPkg::opNop:  ;
            procPkg::opHalt: isHalt = 1'b1;
            default:         illegal = 1'b1;
        endcase
    end

    // Register file reads, same-cycle writeback wins
    assign readA = (wbValid && wbAddr == srcA) ? wbData : regs[srcA];
    assign readB = (wbValid && wbAddr == srcB) ? wbData : regs[srcB];

    // Source still in flight in EX or MEM
    assign hazA  = useA && ((exValid && exRegWrite && exDest == srcA) ||
                            (memValid && memRegWrite && memDest == srcA));
    assign hazB  = useB && ((exValid && exRegWrite && exDest == srcB) ||
                            (memValid && memRegWrite && memDest == srcB));
    assign stall = ifValid && (hazA || hazB);

    // Branch only on up-to-date rs
    assign branchTaken  = ifValid && isBranch && !stall && (readA == '0);
    assign branchTarget = ifPc + 1'b1 + immExt;
    assign haltSeen     = haltReg || (ifValid && isHalt); // Block next fetch at once

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << procPkg::RegAddrWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Sticky flags and ID/EX valid
    always_ff @(posedge clk) begin
        if (reset) begin
            err     <= 1'b0;
            haltReg <= 1'b0;
            exValid <= 1'b0;
        end else begin
            err     <= err || (ifValid && illegal);
            haltReg <= haltSeen;
            exValid <= ifValid && !stall && !illegal; // Bubble on stall or bad opcode
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        exAluOp     <= aluOp;
        exUseImm    <= useImm;
        exOperandA  <= readA;
        exOperandB  <= readB;
        exImm       <= immExt;
        exStoreData <= readB; // rd value for ST
        exDest      <= dest;
        exRegWrite  <= regWrite;
        exMemRead   <= memRead;
        exMemWrite  <= memWrite;
        exHalt      <= isHalt;
    end

endmodule

// ==== source/fetch.sv ====
/* Fetch stage: program counter, loadable instruction memory and IF/ID register
   Holds on stall, redirects and squashes on a taken branch */
module fetch #(
    parameter int ImemWords = 64
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             run,
    input  logic                             imemWrite,
    input  logic [$clog2(ImemWords)-1:0]     imemAddr,
    input  logic [procPkg::DataWidth-1:0]    imemData,
    input  logic                             stall,
    input  logic                             branchTaken,
    input  logic [procPkg::DataWidth-1:0]    branchTarget,
    input  logic                             haltSeen,
    output logic                             ifValid,
    output logic [procPkg::DataWidth-1:0]    ifInstr,
    output logic [procPkg::DataWidth-1:0]    ifPc
);

    logic [procPkg::DataWidth-1:0] imem [ImemWords]; // Word-addressed program store
    logic [procPkg::DataWidth-1:0] pc;
    logic                          issue;

    // Fetch only when running, not held and not past a HALT
    assign issue = run && !stall && !haltSeen;

    // Load port works regardless of run
    always_ff @(posedge clk) begin
        if (imemWrite) begin
            imem[imemAddr] <= imemData;
        end
    end

    // PC and IF/ID valid
    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            ifValid <= 1'b0;
        end else if (branchTaken) begin
            pc      <= branchTarget; // Redirect
            ifValid <= 1'b0;         // Squash wrong-path word
        end else if (issue) begin
            pc      <= pc + 1'b1;
            ifValid <= 1'b1;
        end else if (!stall) begin
            ifValid <= 1'b0;         // Decode took it, nothing new
        end
    end

    // IF/ID payload, frozen while stalled
    always_ff @(posedge clk) begin
        if (issue && !branchTaken) begin
            ifInstr <= imem[pc[$clog2(ImemWords)-1:0]];
            ifPc    <= pc;
        end
    end

endmodule

// ==== source/procPkg.sv ====
/* Shared definitions for the five-stage 16-bit teaching processor
   Widths, opcode and funct encodings, ALU ops and the instruction word views */
package procPkg;

    localparam int DataWidth    = 16; // Data and instruction word
    localparam int RegAddrWidth = 3;  // Eight registers

    // Major opcode, instruction bits 15:11
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opAddi  = 5'b01000,
        opXori  = 5'b01011,
        opBeqz  = 5'b01100,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opRType = 5'b11011
    } opcodeT;

    // R-type function select, bits 1:0
    typedef enum logic [1:0] {
        fnAdd = 2'b00,
        fnSub = 2'b01,
        fnXor = 2'b10,
        fnAnd = 2'b11
    } functT;

    // Operation decode hands to the ALU
    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluSub = 2'b01,
        aluAnd = 2'b10,
        aluXor = 2'b11
    } aluOpT;

    // Register-register layout
    typedef struct packed {
        opcodeT                  opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        functT                   funct;
    } rTypeT;

    // Immediate layout, rd doubles as store source
    typedef struct packed {
        opcodeT                  opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rd;
        logic [4:0]              imm5;
    } iTypeT;

    // Same 16 bits seen either way
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrWord;

endpackage
